/* Makefile */
.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module tb_pmu_ahb -f pmu_ahb.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_pmu_ahb \
		-f pmu_ahb.f -Mdir obj_dir
	./obj_dir/Vtb_pmu_ahb | tee sim.log
	grep -q "^TEST OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* ahb_slave_port.sv */
`include "pmu_ahb_cfg.svh"

module ahb_slave_port import pmu_pkg::*; (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    // AHB-lite slave side
    input  logic                       hsel_i,
    input  logic                       hreadyi_i,
    input  logic [`PMU_ADDR_WIDTH-1:0] haddr_i,
    input  logic                       hwrite_i,
    input  htrans_t                    htrans_i,
    input  reg_word_t                  hwdata_i,
    output logic                       hreadyo_o,
    output hresp_t                     hresp_o,
    output reg_word_t                  hrdata_o,
    // Current register contents for read muxing
    input  reg_bank_t                  regs_i,
    // Write request towards the register bank
    output logic                       wr_en_o,
    output reg_idx_t                   wr_idx_o,
    output reg_word_t                  wr_data_o
);

    // ------------------------------------------------------------------
    // Address phase
    // ------------------------------------------------------------------
    logic     addr_valid;
    reg_idx_t addr_idx;

    // Data phase state, captured at the end of each address phase
    logic     dp_sel_q;
    logic     dp_write_q;
    reg_idx_t dp_idx_q;

    logic     dp_in_range;
    logic     dp_read;

    // Only NONSEQ and SEQ carry a transfer, IDLE and BUSY are ignored
    assign addr_valid = hsel_i && hreadyi_i &&
                        ((htrans_i == HTRANS_NONSEQ) || (htrans_i == HTRANS_SEQ));

    // Word addressed, byte lanes 1:0 dropped
    assign addr_idx = haddr_i[$bits(reg_idx_t)+1:2];

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            dp_sel_q   <= 1'b0;
            dp_write_q <= 1'b0;
            dp_idx_q   <= '0;
        end else begin
            // Select is refreshed every cycle so idle cycles close the pipe
            dp_sel_q <= addr_valid;
            if (addr_valid) begin
                dp_write_q <= hwrite_i;
                dp_idx_q   <= addr_idx;
            end
        end
    end

    // ------------------------------------------------------------------
    // Data phase
    // ------------------------------------------------------------------
    // Indices past the end of the bank are read as zero and never written
    assign dp_in_range = (dp_idx_q < reg_idx_t'(`PMU_N_REGS));

    assign dp_read = dp_sel_q && !dp_write_q;

    // Write pulse lasts exactly the data phase
    assign wr_en_o   = dp_sel_q && dp_write_q && dp_in_range;
    assign wr_idx_o  = dp_idx_q;
    // Write data is valid on hwdata during the data phase itself
    assign wr_data_o = hwdata_i;

    always_comb begin
        if (dp_read && dp_in_range) begin
            hrdata_o = regs_i[dp_idx_q];
        end else begin
            hrdata_o = '0;
        end
    end

    // No wait states, every transfer completes with OKAY
    assign hreadyo_o = 1'b1;
    assign hresp_o   = HRESP_OKAY;

endmodule

/* pmu_ahb.f */
+incdir+.
pmu_pkg.sv
ahb_slave_port.sv
pmu_counter_bank.sv
pmu_regfile.sv
pmu_ahb.sv
pmu_ahb_sva.sv
tb_pmu_ahb.sv

/* pmu_ahb.sv */
`include "pmu_ahb_cfg.svh"

module pmu_ahb import pmu_pkg::*; (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    // AHB-lite slave
    input  logic                       hsel_i,
    input  logic                       hreadyi_i,
    input  logic [`PMU_ADDR_WIDTH-1:0] haddr_i,
    input  logic                       hwrite_i,
    input  htrans_t                    htrans_i,
    input  reg_word_t                  hwdata_i,
    output logic                       hreadyo_o,
    output hresp_t                     hresp_o,
    output reg_word_t                  hrdata_o,
    // Event inputs and overflow interrupt
    input  event_vec_t                 events_i,
    output logic                       intr_overflow_o
);

    // ------------------------------------------------------------------
    // Bus port to register bank
    // ------------------------------------------------------------------
    reg_bank_t regs;
    logic      wr_en;
    reg_idx_t  wr_idx;
    reg_word_t wr_data;

    ahb_slave_port u_ahb_slave_port (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .hsel_i    (hsel_i),
        .hreadyi_i (hreadyi_i),
        .haddr_i   (haddr_i),
        .hwrite_i  (hwrite_i),
        .htrans_i  (htrans_i),
        .hwdata_i  (hwdata_i),
        .hreadyo_o (hreadyo_o),
        .hresp_o   (hresp_o),
        .hrdata_o  (hrdata_o),
        .regs_i    (regs),
        .wr_en_o   (wr_en),
        .wr_idx_o  (wr_idx),
        .wr_data_o (wr_data)
    );

    // Register bank with the counter core inside
    pmu_regfile u_pmu_regfile (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .events_i        (events_i),
        .wr_en_i         (wr_en),
        .wr_idx_i        (wr_idx),
        .wr_data_i       (wr_data),
        .regs_o          (regs),
        .intr_overflow_o (intr_overflow_o)
    );

endmodule

/* pmu_ahb_cfg.svh */
`ifndef PMU_AHB_CFG_SVH
`define PMU_AHB_CFG_SVH

// ----------------------------------------------------------------------
// Bus and register widths
// ----------------------------------------------------------------------
`define PMU_REG_WIDTH 32
`define PMU_ADDR_WIDTH 32

// ----------------------------------------------------------------------
// Register map
// ----------------------------------------------------------------------
`define PMU_N_COUNTERS 9
`define PMU_N_REGS 12

// Config word, bit 0 enables counting and bit 1 clears all counters
`define PMU_CFG_IDX 0
// Counter k lives at index PMU_CNT_BASE + k
`define PMU_CNT_BASE 1
// Sticky overflow flags, one bit per counter
`define PMU_OVF_STATUS_IDX 10
// Interrupt mask, same bit layout as the status word
`define PMU_OVF_MASK_IDX 11

`endif

/* pmu_ahb_sva.sv */
module pmu_ahb_sva import pmu_pkg::*; (
    input logic   clk_i,
    input logic   rstn_i,
    input logic   hreadyo_o,
    input hresp_t hresp_o,
    input logic   intr_overflow_o
);

    // ------------------------------------------------------------------
    // Bus response
    // ------------------------------------------------------------------
    // Slave never inserts wait states, reset included
    a_always_ready: assert property (@(posedge clk_i) hreadyo_o == 1'b1)
        else $error("hreadyo_o went low");

    a_always_okay: assert property (@(posedge clk_i) hresp_o == HRESP_OKAY)
        else $error("hresp_o was not OKAY");

    // ------------------------------------------------------------------
    // Interrupt out of reset
    // ------------------------------------------------------------------
    // Status and mask are both zero right after reset
    a_intr_low_after_reset: assert property (
        @(posedge clk_i) $rose(rstn_i) |=> !intr_overflow_o
    ) else $error("intr_overflow_o high right after reset release");

endmodule

bind pmu_ahb pmu_ahb_sva u_sva (
    .clk_i           (clk_i),
    .rstn_i          (rstn_i),
    .hreadyo_o       (hreadyo_o),
    .hresp_o         (hresp_o),
    .intr_overflow_o (intr_overflow_o)
);

/* pmu_counter_bank.sv */
`include "pmu_ahb_cfg.svh"

module pmu_counter_bank import pmu_pkg::*; (
    // One level per counter, sampled at the clock edge
    input  event_vec_t                         events_i,
    // Control bits from the config register
    input  logic                               count_en_i,
    input  logic                               count_clr_i,
    // Current counter values
    input  reg_word_t [`PMU_N_COUNTERS-1:0]    counters_i,
    // Register being written by the bus this cycle
    input  logic                               skip_idx_valid_i,
    input  reg_idx_t                           skip_idx_i,
    // Next counter values and wrap flags
    output reg_word_t [`PMU_N_COUNTERS-1:0]    counters_o,
    output event_vec_t                         wrap_o
);

    // ------------------------------------------------------------------
    // Per-counter next-state logic
    // ------------------------------------------------------------------
    for (genvar k = 0; k < `PMU_N_COUNTERS; k++) begin : g_cnt

        // Register index this counter occupies in the bank
        localparam reg_idx_t CNT_IDX = reg_idx_t'(`PMU_CNT_BASE + k);

        logic      skip;
        logic      bump;
        reg_word_t cnt_next;

        // Bus write to this counter wins, so it neither counts nor wraps
        assign skip = skip_idx_valid_i && (skip_idx_i == CNT_IDX);

        // Counts only when enabled, not being cleared and the event is high
        assign bump = count_en_i && !count_clr_i && events_i[k] && !skip;

        always_comb begin
            if (skip) begin
                cnt_next = counters_i[k];
            end else if (count_clr_i) begin
                // Clear holds every counter at zero while the bit stays set
                cnt_next = '0;
            end else if (bump) begin
                // Natural wrap from all-ones to zero
                cnt_next = counters_i[k] + 1'b1;
            end else begin
                cnt_next = counters_i[k];
            end
        end

        assign counters_o[k] = cnt_next;

        // Wrap only when this very increment rolls over
        assign wrap_o[k] = bump && (counters_i[k] == '1);

    end

endmodule

/* pmu_pkg.sv */
`include "pmu_ahb_cfg.svh"

package pmu_pkg;

    // ------------------------------------------------------------------
    // AHB encodings
    // ------------------------------------------------------------------
    // Transfer type as driven on htrans
    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htrans_t;

    // Slave response, this slave only ever answers OKAY
    typedef enum logic {
        HRESP_OKAY  = 1'b0,
        HRESP_ERROR = 1'b1
    } hresp_t;

    // ------------------------------------------------------------------
    // Register bank types
    // ------------------------------------------------------------------
    typedef logic [`PMU_REG_WIDTH-1:0] reg_word_t;
    // Wide enough to address every register in the bank
    typedef logic [$clog2(`PMU_N_REGS)-1:0] reg_idx_t;
    typedef logic [`PMU_N_COUNTERS-1:0] event_vec_t;
    // Whole bank flattened, entry i is register i
    typedef reg_word_t [`PMU_N_REGS-1:0] reg_bank_t;

endpackage

/* pmu_regfile.sv */
`include "pmu_ahb_cfg.svh"

module pmu_regfile import pmu_pkg::*; (
    input  logic       clk_i,
    input  logic       rstn_i,
    // Event levels, one per counter
    input  event_vec_t events_i,
    // Bus write request, valid during the data phase
    input  logic       wr_en_i,
    input  reg_idx_t   wr_idx_i,
    input  reg_word_t  wr_data_i,
    // Registered bank, read back by the bus port
    output reg_bank_t  regs_o,
    // Level interrupt, any unmasked overflow flag
    output logic       intr_overflow_o
);

    // ------------------------------------------------------------------
    // Register storage
    // ------------------------------------------------------------------
    reg_bank_t regs_q;
    reg_bank_t regs_d;

    // Config fields
    reg_word_t cfg_word;
    logic      count_en;
    logic      count_clr;

    // Counter slice of the bank and its next value
    reg_word_t [`PMU_N_COUNTERS-1:0] cnt_cur;
    reg_word_t [`PMU_N_COUNTERS-1:0] cnt_next;
    event_vec_t                      cnt_wrap;

    // Overflow status and mask, counter bits only
    event_vec_t ovf_status;
    event_vec_t ovf_mask;

    assign cfg_word  = regs_q[`PMU_CFG_IDX];
    assign count_en  = cfg_word[0];
    assign count_clr = cfg_word[1];

    // Counters occupy a contiguous run starting at PMU_CNT_BASE
    assign cnt_cur = regs_q[`PMU_CNT_BASE +: `PMU_N_COUNTERS];

    pmu_counter_bank u_counter_bank (
        .events_i         (events_i),
        .count_en_i       (count_en),
        .count_clr_i      (count_clr),
        .counters_i       (cnt_cur),
        .skip_idx_valid_i (wr_en_i),
        .skip_idx_i       (wr_idx_i),
        .counters_o       (cnt_next),
        .wrap_o           (cnt_wrap)
    );

    // ------------------------------------------------------------------
    // Next-state merge
    // ------------------------------------------------------------------
    always_comb begin
        regs_d = regs_q;
        // Hardware updates first
        regs_d[`PMU_CNT_BASE +: `PMU_N_COUNTERS] = cnt_next;
        regs_d[`PMU_OVF_STATUS_IDX] = regs_q[`PMU_OVF_STATUS_IDX] | reg_word_t'(cnt_wrap);
        // Bus write then overrides its target
        if (wr_en_i) begin
            regs_d[wr_idx_i] = wr_data_i;
            // Fresh wraps still land even when software rewrites the status
            if (wr_idx_i == reg_idx_t'(`PMU_OVF_STATUS_IDX)) begin
                regs_d[`PMU_OVF_STATUS_IDX] = wr_data_i | reg_word_t'(cnt_wrap);
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            regs_q <= '0;
        end else begin
            regs_q <= regs_d;
        end
    end

    assign regs_o = regs_q;

    // ------------------------------------------------------------------
    // Overflow interrupt
    // ------------------------------------------------------------------
    assign ovf_status = regs_q[`PMU_OVF_STATUS_IDX][`PMU_N_COUNTERS-1:0];
    assign ovf_mask   = regs_q[`PMU_OVF_MASK_IDX][`PMU_N_COUNTERS-1:0];

    // Straight from flops, so it follows the wrapping edge by one cycle
    assign intr_overflow_o = |(ovf_status & ovf_mask);

endmodule

/* tb_pmu_ahb.sv */
`include "pmu_ahb_cfg.svh"

module tb_pmu_ahb import pmu_pkg::*; ();

    // Roughly ten times the cycles all tests need together
    localparam int MAX_CYCLES = 3000;

    logic                       clk_i;
    logic                       rstn_i;
    logic                       hsel_i;
    logic                       hreadyi_i;
    logic [`PMU_ADDR_WIDTH-1:0] haddr_i;
    logic                       hwrite_i;
    htrans_t                    htrans_i;
    reg_word_t                  hwdata_i;
    logic                       hreadyo_o;
    hresp_t                     hresp_o;
    reg_word_t                  hrdata_o;
    event_vec_t                 events_i;
    logic                       intr_overflow_o;

    // Expected contents of every register
    reg_word_t exp_regs [`PMU_N_REGS];
    integer    seed = 32'heb6;
    int        err_count = 0;
    int        tests_passed = 0;
    int        tests_failed = 0;
    int        cycles = 0;

    pmu_ahb DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // Run limit
    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("Timeout: tests did not finish within %0d cycles", MAX_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    // ------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------
    task automatic check_word(input string name, input reg_word_t exp, input reg_word_t act);
        if (act !== exp) begin
            $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error at %0t: %s expected %b, got %b", $time, name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_resp(input hresp_t exp, input hresp_t act, input logic ready);
        if (act !== exp) begin
            $display("Error at %0t: hresp_o expected %0d, got %0d", $time, exp, act);
            err_count++;
        end
        if (ready !== 1'b1) begin
            $display("Error at %0t: hreadyo_o expected 1, got %b", $time, ready);
            err_count++;
        end
    endtask

    // ------------------------------------------------------------------
    // Bus tasks
    // ------------------------------------------------------------------
    task automatic ahb_addr(input int idx, input logic write);
        hsel_i   <= 1'b1;
        htrans_i <= HTRANS_NONSEQ;
        haddr_i  <= idx * 4;
        hwrite_i <= write;
    endtask

    task automatic ahb_idle();
        hsel_i   <= 1'b0;
        htrans_i <= HTRANS_IDLE;
        hwrite_i <= 1'b0;
    endtask

    // Returns inside the data phase, the write lands at the next edge
    task automatic ahb_write(input int idx, input reg_word_t data);
        @(posedge clk_i);
        ahb_addr(idx, 1'b1);
        @(posedge clk_i);
        ahb_idle();
        hwdata_i <= data;
    endtask

    task automatic ahb_read(input int idx, output reg_word_t data);
        @(posedge clk_i);
        ahb_addr(idx, 1'b0);
        @(posedge clk_i);
        ahb_idle();
        // Mid data phase, hrdata is settled
        @(negedge clk_i);
        data = hrdata_o;
        check_resp(HRESP_OKAY, hresp_o, hreadyo_o);
    endtask

    task automatic check_regs();
        reg_word_t rd;
        for (int i = 0; i < `PMU_N_REGS; i++) begin
            ahb_read(i, rd);
            check_word($sformatf("reg[%0d]", i), exp_regs[i], rd);
        end
    endtask

    // Let a pending write land, then sample mid cycle
    task automatic settle();
        @(posedge clk_i);
        @(negedge clk_i);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            tests_passed++;
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    // ------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------
    task automatic test_reset();
        int e;
        e = err_count;
        repeat (2) @(posedge clk_i);
        // Response must already be OKAY and ready while reset is held
        @(negedge clk_i);
        check_resp(HRESP_OKAY, hresp_o, hreadyo_o);
        // Third rising edge under reset, then release
        @(posedge clk_i);
        rstn_i <= 1'b1;
        foreach (exp_regs[i]) exp_regs[i] = '0;
        check_regs();
        check_level("intr_overflow_o", 1'b0, intr_overflow_o);
        finish_test("reset", e);
    endtask

    task automatic test_regs();
        int        e;
        reg_word_t rd;
        e = err_count;
        exp_regs[`PMU_OVF_MASK_IDX]   = reg_word_t'($random(seed));
        exp_regs[`PMU_OVF_STATUS_IDX] = reg_word_t'($random(seed));
        exp_regs[`PMU_CFG_IDX]        = reg_word_t'($random(seed));
        ahb_write(`PMU_OVF_MASK_IDX, exp_regs[`PMU_OVF_MASK_IDX]);
        ahb_write(`PMU_OVF_STATUS_IDX, exp_regs[`PMU_OVF_STATUS_IDX]);
        ahb_write(`PMU_CFG_IDX, exp_regs[`PMU_CFG_IDX]);
        // Out of range index, must not alias onto any register
        ahb_write(13, reg_word_t'($random(seed)));
        check_regs();
        ahb_read(13, rd);
        check_word("reg[13]", '0, rd);
        ahb_write(`PMU_CFG_IDX, '0);
        ahb_write(`PMU_OVF_STATUS_IDX, '0);
        ahb_write(`PMU_OVF_MASK_IDX, '0);
        exp_regs[`PMU_CFG_IDX]        = '0;
        exp_regs[`PMU_OVF_STATUS_IDX] = '0;
        exp_regs[`PMU_OVF_MASK_IDX]   = '0;
        finish_test("register access", e);
    endtask

    task automatic test_pipeline();
        int        e;
        reg_word_t rd;
        e = err_count;
        exp_regs[`PMU_CNT_BASE]     = reg_word_t'($random(seed));
        exp_regs[`PMU_CNT_BASE + 1] = reg_word_t'($random(seed));
        exp_regs[`PMU_CNT_BASE + 2] = reg_word_t'($random(seed));
        // Read address phase overlaps the write data phase
        @(posedge clk_i);
        ahb_addr(`PMU_CNT_BASE, 1'b1);
        @(posedge clk_i);
        hwdata_i <= exp_regs[`PMU_CNT_BASE];
        ahb_addr(`PMU_CNT_BASE, 1'b0);
        @(posedge clk_i);
        ahb_idle();
        @(negedge clk_i);
        rd = hrdata_o;
        check_word("hrdata_o", exp_regs[`PMU_CNT_BASE], rd);
        // Two writes back to back
        @(posedge clk_i);
        ahb_addr(`PMU_CNT_BASE + 1, 1'b1);
        @(posedge clk_i);
        hwdata_i <= exp_regs[`PMU_CNT_BASE + 1];
        ahb_addr(`PMU_CNT_BASE + 2, 1'b1);
        @(posedge clk_i);
        hwdata_i <= exp_regs[`PMU_CNT_BASE + 2];
        ahb_idle();
        check_regs();
        finish_test("pipelined access", e);
    endtask

    task automatic test_count();
        int         e;
        event_vec_t ev;
        e = err_count;
        ahb_write(`PMU_CFG_IDX, 32'h2);
        ahb_write(`PMU_CFG_IDX, 32'h1);
        for (int k = 0; k < `PMU_N_COUNTERS; k++) exp_regs[`PMU_CNT_BASE + k] = '0;
        repeat (40) begin
            @(posedge clk_i);
            ev = event_vec_t'($random(seed));
            events_i <= ev;
            for (int k = 0; k < `PMU_N_COUNTERS; k++) begin
                if (ev[k]) exp_regs[`PMU_CNT_BASE + k] = exp_regs[`PMU_CNT_BASE + k] + 1;
            end
        end
        @(posedge clk_i);
        events_i <= '0;
        ahb_write(`PMU_CFG_IDX, '0);
        check_regs();
        // Clear bit zeroes every counter
        ahb_write(`PMU_CFG_IDX, 32'h2);
        exp_regs[`PMU_CFG_IDX] = 32'h2;
        for (int k = 0; k < `PMU_N_COUNTERS; k++) exp_regs[`PMU_CNT_BASE + k] = '0;
        check_regs();
        ahb_write(`PMU_CFG_IDX, '0);
        exp_regs[`PMU_CFG_IDX] = '0;
        finish_test("counting", e);
    endtask

    task automatic test_overflow();
        int e;
        e = err_count;
        ahb_write(`PMU_CNT_BASE + 3, 32'hFFFF_FFFE);
        ahb_write(`PMU_OVF_MASK_IDX, 32'h8);
        ahb_write(`PMU_CFG_IDX, 32'h1);
        // Two events, second one wraps counter 3
        repeat (2) begin
            @(posedge clk_i);
            events_i <= 9'h008;
        end
        @(posedge clk_i);
        events_i <= '0;
        ahb_write(`PMU_CFG_IDX, '0);
        exp_regs[`PMU_CNT_BASE + 3]   = '0;
        exp_regs[`PMU_OVF_STATUS_IDX] = 32'h8;
        exp_regs[`PMU_OVF_MASK_IDX]   = 32'h8;
        check_regs();
        check_level("intr_overflow_o", 1'b1, intr_overflow_o);
        ahb_write(`PMU_OVF_MASK_IDX, '0);
        settle();
        check_level("intr_overflow_o", 1'b0, intr_overflow_o);
        // Status cleared, so restoring the mask keeps the line low
        ahb_write(`PMU_OVF_STATUS_IDX, '0);
        ahb_write(`PMU_OVF_MASK_IDX, 32'h8);
        settle();
        check_level("intr_overflow_o", 1'b0, intr_overflow_o);
        exp_regs[`PMU_OVF_STATUS_IDX] = '0;
        check_regs();
        finish_test("overflow", e);
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        rstn_i    = 1'b0;
        hsel_i    = 1'b0;
        hreadyi_i = 1'b1;
        haddr_i   = '0;
        hwrite_i  = 1'b0;
        htrans_i  = HTRANS_IDLE;
        hwdata_i  = '0;
        events_i  = '0;
        test_reset();
        test_regs();
        test_pipeline();
        test_count();
        test_overflow();
        $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
